// File: Makefile
SIM        := verilator
SIM_FLAGS  := --binary --timing
LINT_FLAGS := --lint-only --timing
TOP        := tb_experiar_soc
FILELIST   := tb.f
OBJ_DIR    := obj_dir
PASS_MSG   := Simulation passed

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: design/experiar_soc.sv
`timescale 1ns/10ps
`default_nettype none

module experiar_soc
	import soc_pkg::*;
#(
	parameter int SRAM_ADDR_W = 9
) (
	input wire logic wb_clk_i,
	input wire logic rst_n_i,

	// Management port
	input wire wb_req_t m0_req_i,
	output wb_rsp_t m0_rsp_o,

	// Second external master
	input wire wb_req_t m1_req_i,
	output wb_rsp_t m1_rsp_o,

	output soc_probe_t probe_o
);

	wb_req_t m_req [NUM_MASTERS];
	wb_rsp_t m_rsp [NUM_MASTERS];

	// Master side indexed by [master][slave]
	wb_slv_req_t mst_slv_req [NUM_MASTERS][NUM_SLAVES];
	wb_rsp_t mst_slv_rsp [NUM_MASTERS][NUM_SLAVES];

	// Arbiter side indexed by [slave][master]
	wb_slv_req_t arb_mst_req [NUM_SLAVES][NUM_MASTERS];
	wb_rsp_t arb_mst_rsp [NUM_SLAVES][NUM_MASTERS];

	wb_slv_req_t mem_req [NUM_SLAVES];
	wb_rsp_t mem_rsp [NUM_SLAVES];

	slave_sel_e cur_slave [NUM_MASTERS];
	master_sel_t cur_master [NUM_SLAVES];

	assign m_req[0] = m0_req_i;
	assign m_req[1] = m1_req_i;
	assign m0_rsp_o = m_rsp[0];
	assign m1_rsp_o = m_rsp[1];

	for (genvar m = 0; m < NUM_MASTERS; m++) begin : master_g
		wb_master_port u_port (
			.wb_clk_i(wb_clk_i),
			.rst_n_i(rst_n_i),
			.req_i(m_req[m]),
			.rsp_o(m_rsp[m]),
			.slv_req_o(mst_slv_req[m]),
			.slv_rsp_i(mst_slv_rsp[m]),
			.cur_slave_o(cur_slave[m])
		);

		// Crossbar wiring between ports and arbiters
		for (genvar s = 0; s < NUM_SLAVES; s++) begin : xbar_g
			assign arb_mst_req[s][m] = mst_slv_req[m][s];
			assign mst_slv_rsp[m][s] = arb_mst_rsp[s][m];
		end
	end

	for (genvar s = 0; s < NUM_SLAVES; s++) begin : slave_g
		wb_slave_arbiter #(
			.NUM_MASTERS(NUM_MASTERS)
		) u_arb (
			.wb_clk_i(wb_clk_i),
			.rst_n_i(rst_n_i),
			.mst_req_i(arb_mst_req[s]),
			.mst_rsp_o(arb_mst_rsp[s]),
			.slv_req_o(mem_req[s]),
			.slv_rsp_i(mem_rsp[s]),
			.cur_master_o(cur_master[s])
		);

		sram_bank_pair #(
			.SRAM_ADDR_W(SRAM_ADDR_W)
		) u_mem (
			.wb_clk_i(wb_clk_i),
			.rst_n_i(rst_n_i),
			.req_i(mem_req[s]),
			.rsp_o(mem_rsp[s])
		);
	end

	// Logic analyzer word
	assign probe_o.slv1_master = cur_master[1];
	assign probe_o.slv0_master = cur_master[0];
	assign probe_o.mst1_slave = cur_slave[1];
	assign probe_o.mst0_slave = cur_slave[0];

endmodule

`default_nettype wire

// File: design/soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus geometry
	localparam int NUM_MASTERS = 2;
	localparam int NUM_SLAVES = 2;

	// Address bits 27..24 pick the slave
	localparam int SLAVE_FIELD_MSB = 27;
	localparam int SLAVE_FIELD_LSB = 24;
	localparam logic [SLAVE_FIELD_MSB-SLAVE_FIELD_LSB:0] MEM0_REGION = 4'd0;
	localparam logic [SLAVE_FIELD_MSB-SLAVE_FIELD_LSB:0] MEM1_REGION = 4'd1;

	typedef logic [31:0] wb_data_t;
	typedef logic [3:0] wb_sel_t;
	typedef logic [27:0] wb_addr_t;
	typedef logic [23:0] slv_addr_t;

	// Request from a master with the full address
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		wb_addr_t adr;
		wb_data_t data;
	} wb_req_t;

	// Request toward a slave without the region bits
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		slv_addr_t adr;
		wb_data_t data;
	} wb_slv_req_t;

	typedef struct packed {
		logic ack;
		logic stall;
		logic err;
		wb_data_t data;
	} wb_rsp_t;

	// Slave a master talks to with the slave number as its encoding
	typedef enum logic [1:0] {
		SEL_MEM0 = 2'd0,
		SEL_MEM1 = 2'd1,
		SEL_NONE = 2'd3
	} slave_sel_e;

	// Granted master index plus one or zero when idle
	typedef logic [1:0] master_sel_t;

	// Interconnect probe with the slaves in the upper half
	typedef struct packed {
		master_sel_t slv1_master;
		master_sel_t slv0_master;
		slave_sel_e mst1_slave;
		slave_sel_e mst0_slave;
	} soc_probe_t;

endpackage

`default_nettype wire

// File: design/sram_bank_pair.sv
`timescale 1ns/10ps
`default_nettype none

module sram_bank_pair
	import soc_pkg::*;
#(
	parameter int SRAM_ADDR_W = 9
) (
	input wire logic wb_clk_i,
	input wire logic rst_n_i,
	input wire wb_slv_req_t req_i,
	output wb_rsp_t rsp_o
);

	localparam int DEPTH = 2 ** SRAM_ADDR_W;

	logic access;
	logic [SRAM_ADDR_W-1:0] addr;
	logic bank_sel;
	logic [1:0] csb;
	logic web;
	wb_sel_t wmask;
	logic [63:0] dout;
	logic bank_q;
	logic ack_q;

	// Word index above the byte lane, bank bit just above that
	assign access = req_i.cyc & req_i.stb;
	assign addr = req_i.adr[SRAM_ADDR_W+1:2];
	assign bank_sel = req_i.adr[SRAM_ADDR_W+2];

	// Macro style active-low controls
	assign csb[0] = ~(access & ~bank_sel);
	assign csb[1] = ~(access & bank_sel);
	assign web = ~req_i.we;
	assign wmask = req_i.sel;

	for (genvar b = 0; b < 2; b++) begin : bank_g
		wb_data_t mem [DEPTH];
		wb_data_t dout_q;

		always_ff @(posedge wb_clk_i) begin
			if (!csb[b]) begin
				if (!web) begin
					for (int i = 0; i < 4; i++) begin
						if (wmask[i]) begin
							mem[addr][8*i +: 8] <= req_i.data[8*i +: 8];
						end
					end
				end else begin
					dout_q <= mem[addr];
				end
			end
		end
	end

	assign dout = {bank_g[1].dout_q, bank_g[0].dout_q};

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			bank_q <= bank_sel;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// Never stalls, never errs
	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.stall = 1'b0;
		rsp_o.err = 1'b0;
		rsp_o.data = bank_q ? dout[63:32] : dout[31:0];
	end

endmodule

`default_nettype wire

// File: design/wb_master_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_master_port
	import soc_pkg::*;
(
	input wire logic wb_clk_i,
	input wire logic rst_n_i,
	input wire wb_req_t req_i,
	output wb_rsp_t rsp_o,
	output wb_slv_req_t slv_req_o [NUM_SLAVES],
	input wire wb_rsp_t slv_rsp_i [NUM_SLAVES],
	output slave_sel_e cur_slave_o
);

	logic [SLAVE_FIELD_MSB-SLAVE_FIELD_LSB:0] region;
	slave_sel_e dec_sel;
	slave_sel_e route_sel;
	slave_sel_e target_q;
	logic pending_q;
	logic err_q;
	logic accept;

	// Address decode
	assign region = req_i.adr[SLAVE_FIELD_MSB:SLAVE_FIELD_LSB];

	always_comb begin
		if (region == MEM0_REGION) begin
			dec_sel = SEL_MEM0;
		end else if (region == MEM1_REGION) begin
			dec_sel = SEL_MEM1;
		end else begin
			dec_sel = SEL_NONE;
		end
	end

	// Hold cyc on the latched slave until the response is back
	assign route_sel = pending_q ? target_q : dec_sel;

	always_comb begin
		for (int s = 0; s < NUM_SLAVES; s++) begin
			slv_req_o[s].cyc = req_i.cyc && (route_sel == slave_sel_e'(s));
			slv_req_o[s].stb = req_i.stb && !pending_q && (dec_sel == slave_sel_e'(s));
			slv_req_o[s].we = req_i.we;
			slv_req_o[s].sel = req_i.sel;
			slv_req_o[s].adr = req_i.adr[SLAVE_FIELD_LSB-1:0];
			slv_req_o[s].data = req_i.data;
		end
	end

	// Merge the arbiter responses with the local error
	always_comb begin
		rsp_o = '0;
		rsp_o.err = err_q;
		rsp_o.stall = pending_q;
		for (int s = 0; s < NUM_SLAVES; s++) begin
			if (pending_q && target_q == slave_sel_e'(s)) begin
				rsp_o.ack = slv_rsp_i[s].ack;
				rsp_o.err = err_q | slv_rsp_i[s].err;
				rsp_o.data = slv_rsp_i[s].data;
			end
			if (!pending_q && dec_sel == slave_sel_e'(s)) begin
				rsp_o.stall = slv_rsp_i[s].stall;
			end
		end
	end

	assign accept = req_i.cyc && req_i.stb && !rsp_o.stall;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			pending_q <= 1'b0;
			target_q <= SEL_NONE;
			err_q <= 1'b0;
		end else begin
			// Unmapped access answers with err on the next cycle
			err_q <= accept && (dec_sel == SEL_NONE);
			if (accept) begin
				pending_q <= 1'b1;
				target_q <= dec_sel;
			end else if (rsp_o.ack || rsp_o.err || !req_i.cyc) begin
				pending_q <= 1'b0;
			end
		end
	end

	// Probe view
	assign cur_slave_o = req_i.cyc ? route_sel : SEL_NONE;

endmodule

`default_nettype wire

// File: design/wb_slave_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module wb_slave_arbiter
	import soc_pkg::*;
#(
	parameter int NUM_MASTERS = soc_pkg::NUM_MASTERS
) (
	input wire logic wb_clk_i,
	input wire logic rst_n_i,
	input wire wb_slv_req_t mst_req_i [NUM_MASTERS],
	output wb_rsp_t mst_rsp_o [NUM_MASTERS],
	output wb_slv_req_t slv_req_o,
	input wire wb_rsp_t slv_rsp_i,
	output master_sel_t cur_master_o
);

	master_sel_t grant_q;
	master_sel_t cur_grant;
	logic [NUM_MASTERS-1:0] req_v;
	logic holder_cyc;

	// Grant selection
	always_comb begin
		holder_cyc = 1'b0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			req_v[m] = mst_req_i[m].cyc & mst_req_i[m].stb;
			if (grant_q == master_sel_t'(m + 1)) begin
				holder_cyc = mst_req_i[m].cyc;
			end
		end

		cur_grant = '0;
		if (grant_q != '0 && holder_cyc) begin
			// Locked while the owner keeps cyc
			cur_grant = grant_q;
		end else begin
			// Lowest index wins when free
			for (int m = NUM_MASTERS - 1; m >= 0; m--) begin
				if (req_v[m]) begin
					cur_grant = master_sel_t'(m + 1);
				end
			end
		end
	end

	// Request mux and response routing
	always_comb begin
		slv_req_o = '0;
		for (int m = 0; m < NUM_MASTERS; m++) begin
			mst_rsp_o[m] = '0;
			if (cur_grant == master_sel_t'(m + 1)) begin
				slv_req_o = mst_req_i[m];
				mst_rsp_o[m] = slv_rsp_i;
			end else begin
				mst_rsp_o[m].stall = req_v[m];
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			grant_q <= '0;
		end else begin
			grant_q <= cur_grant;
		end
	end

	assign cur_master_o = cur_grant;

endmodule

`default_nettype wire

// File: sim/tb_experiar_soc.sv
`timescale 1ns/10ps
`default_nettype none

module tb_experiar_soc
	import soc_pkg::*;
();

	localparam int CLK_PERIOD = 4;
	localparam int DRIVE_DELAY = 1;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_PER_MASTER = 130;
	// Fill, directed and random accesses stay below this count
	localparam int NUM_TRANSACTIONS = 400;
	localparam int CYCLES_PER_TRANSACTION = 20;
	localparam int TIMEOUT_CYCLES = NUM_TRANSACTIONS * CYCLES_PER_TRANSACTION;

	logic wb_clk;
	logic rst_n;
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;
	soc_probe_t probe;
	integer seed;
	int cycle_count = 0;

	// Two byte addressed memories of 4 KB each
	logic [7:0] model_mem [0:8191];

	experiar_soc #(
		.SRAM_ADDR_W(9)
	) i_experiar_soc (
		.wb_clk_i(wb_clk),
		.rst_n_i(rst_n),
		.m0_req_i(m0_req),
		.m0_rsp_o(m0_rsp),
		.m1_req_i(m1_req),
		.m1_rsp_o(m1_rsp),
		.probe_o(probe)
	);

	always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;

	always @(posedge wb_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1);
		end
	end

	task automatic report_failure(input string what);
		$display("error at %0t ns: %s", $time, what);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_rsp(input wb_data_t got, input wb_data_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic check_probe(input soc_probe_t got, input soc_probe_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	// Address fields from the region down to the byte lane
	function automatic wb_addr_t make_addr(input logic [3:0] region,
			input logic [11:0] alias_bits, input logic bank, input logic [8:0] word,
			input logic [1:0] lane);
		return {region, alias_bits, bank, word, lane};
	endfunction

	function automatic int byte_index(input wb_addr_t adr, input int lane);
		return int'(adr[24]) * 4096 + int'(adr[11:2]) * 4 + lane;
	endfunction

	function automatic logic is_mapped(input wb_addr_t adr);
		return (adr[27:24] == MEM0_REGION) || (adr[27:24] == MEM1_REGION);
	endfunction

	task automatic model_write(input wb_addr_t adr, input wb_sel_t sel, input wb_data_t data);
		for (int lane = 0; lane < 4; lane++) begin
			if (sel[lane]) model_mem[byte_index(adr, lane)] = data[8*lane +: 8];
		end
	endtask

	function automatic wb_data_t model_read(input wb_addr_t adr);
		wb_data_t word;
		for (int lane = 0; lane < 4; lane++) begin
			word[8*lane +: 8] = model_mem[byte_index(adr, lane)];
		end
		return word;
	endfunction

	function automatic soc_probe_t idle_probe();
		soc_probe_t p;
		p.slv1_master = '0;
		p.slv0_master = '0;
		p.mst1_slave = SEL_NONE;
		p.mst0_slave = SEL_NONE;
		return p;
	endfunction

	// Probe while master m alone holds cyc toward the given region
	function automatic soc_probe_t expected_probe(input int m, input logic [3:0] region);
		soc_probe_t p;
		slave_sel_e s;
		p = idle_probe();
		if (region == 4'd0) s = SEL_MEM0;
		else if (region == 4'd1) s = SEL_MEM1;
		else s = SEL_NONE;
		if (m == 0) p.mst0_slave = s;
		else p.mst1_slave = s;
		if (s == SEL_MEM0) p.slv0_master = master_sel_t'(m + 1);
		else if (s == SEL_MEM1) p.slv1_master = master_sel_t'(m + 1);
		return p;
	endfunction

	task automatic drive_req(input int m, input wb_req_t r);
		if (m == 0) m0_req = r;
		else m1_req = r;
	endtask

	function automatic wb_rsp_t rsp_of(input int m);
		return (m == 0) ? m0_rsp : m1_rsp;
	endfunction

	// One complete bus cycle that returns DRIVE_DELAY after a rising edge
	task automatic bus_access(input int m, input logic we, input wb_addr_t adr,
			input wb_sel_t sel, input wb_data_t wdata, input logic solo,
			output wb_data_t rdata);
		wb_req_t req;
		wb_rsp_t rsp;
		logic mapped;
		int waits;
		mapped = is_mapped(adr);
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.adr = adr;
		req.data = wdata;
		drive_req(m, req);
		do begin
			@(negedge wb_clk);
			rsp = rsp_of(m);
			if (rsp.ack || rsp.err) report_failure("response before the request was accepted");
		end while (rsp.stall);
		@(posedge wb_clk);
		#DRIVE_DELAY;
		req.stb = 1'b0;
		drive_req(m, req);
		// Keep cyc until ack or err
		waits = 0;
		do begin
			@(negedge wb_clk);
			waits++;
			rsp = rsp_of(m);
			if (solo) check_probe(probe, expected_probe(m, adr[27:24]), "probe during cycle");
		end while (!rsp.ack && !rsp.err);
		// Without contention the answer comes one cycle after acceptance
		if (solo && waits != 1) begin
			report_failure("response did not come one cycle after acceptance");
		end
		if (rsp.ack && rsp.err) report_failure("ack and err in the same cycle");
		if (mapped && !rsp.ack) report_failure("mapped access ended in err");
		if (!mapped && !rsp.err) report_failure("unmapped access ended in ack");
		rdata = rsp.data;
		@(posedge wb_clk);
		#DRIVE_DELAY;
		drive_req(m, '0);
		@(negedge wb_clk);
		rsp = rsp_of(m);
		if (rsp.ack || rsp.err) report_failure("second response to a single request");
		@(posedge wb_clk);
		#DRIVE_DELAY;
	endtask

	task automatic write_word(input int m, input wb_addr_t adr, input wb_sel_t sel,
			input wb_data_t data, input logic solo);
		wb_data_t discard;
		bus_access(m, 1'b1, adr, sel, data, solo, discard);
		if (is_mapped(adr)) model_write(adr, sel, data);
	endtask

	task automatic read_check(input int m, input wb_addr_t adr, input logic solo);
		wb_data_t rdata;
		bus_access(m, 1'b0, adr, 4'hf, '0, solo, rdata);
		if (is_mapped(adr)) check_rsp(rdata, model_read(adr), "read data");
	endtask

	// Even words belong to master 0, odd words to master 1
	task automatic fill_pool(input int m);
		for (int s = 0; s < 2; s++) begin
			for (int b = 0; b < 2; b++) begin
				for (int k = 0; k < 8; k++) begin
					write_word(m, make_addr(4'(s), 12'h000, 1'(b), 9'(2 * k + m), 2'b00),
						4'hf, $random(seed), 1'b0);
				end
			end
		end
	endtask

	task automatic directed_checks();
		wb_addr_t a;
		wb_addr_t b;
		// Partial write through the byte mask
		a = make_addr(4'd0, 12'h000, 1'b0, 9'd2, 2'b00);
		write_word(0, a, 4'hf, 32'h1122_3344, 1'b1);
		write_word(0, a, 4'b0101, 32'haabb_ccdd, 1'b1);
		read_check(0, a, 1'b1);
		// 4 KB aliases and the two banks
		a = make_addr(4'd1, 12'h000, 1'b0, 9'd3, 2'b00);
		b = make_addr(4'd1, 12'h000, 1'b1, 9'd3, 2'b00);
		write_word(1, a, 4'hf, 32'h0bad_f00d, 1'b1);
		write_word(1, b, 4'hf, 32'h5eed_0044, 1'b1);
		read_check(1, make_addr(4'd1, 12'h5a3, 1'b0, 9'd3, 2'b10), 1'b1);
		read_check(1, make_addr(4'd1, 12'hfff, 1'b1, 9'd3, 2'b01), 1'b1);
		// Unmapped regions 2 and 3 share bit 24 patterns with the memories
		write_word(0, make_addr(4'd2, 12'h000, 1'b0, 9'd2, 2'b00), 4'hf, 32'hdead_beef, 1'b1);
		write_word(0, make_addr(4'd3, 12'h000, 1'b0, 9'd2, 2'b00), 4'hf, 32'hfeed_cafe, 1'b1);
		read_check(0, make_addr(4'd9, 12'h000, 1'b0, 9'd2, 2'b00), 1'b1);
		read_check(0, make_addr(4'd0, 12'h000, 1'b0, 9'd2, 2'b00), 1'b1);
		read_check(0, make_addr(4'd1, 12'h000, 1'b0, 9'd2, 2'b00), 1'b1);
	endtask

	task automatic random_traffic(input int m, input int count);
		logic [31:0] rnd;
		logic [3:0] region;
		wb_addr_t adr;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			// About one access in sixteen is unmapped
			if (rnd[3:0] == 4'h0) region = rnd[7:4] | 4'b0010;
			else region = {3'b000, rnd[4]};
			adr = make_addr(region, rnd[22:11], rnd[23], {5'b00000, rnd[10:8], m[0]},
				rnd[25:24]);
			if (rnd[26]) write_word(m, adr, rnd[30:27], $random(seed), 1'b0);
			else read_check(m, adr, 1'b0);
			if (rnd[31]) begin
				@(posedge wb_clk);
				#DRIVE_DELAY;
			end
		end
	endtask

	initial begin
		wb_clk = 1'b0;
		rst_n = 1'b0;
		m0_req = '0;
		m1_req = '0;
		seed = 68;
		repeat (RESET_CYCLES) @(posedge wb_clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		// Idle bus right after reset
		@(negedge wb_clk);
		if (m0_rsp.ack || m0_rsp.err || m0_rsp.stall) report_failure("master 0 not idle");
		if (m1_rsp.ack || m1_rsp.err || m1_rsp.stall) report_failure("master 1 not idle");
		check_probe(probe, idle_probe(), "probe after reset");
		@(posedge wb_clk);
		#DRIVE_DELAY;
		fork
			fill_pool(0);
			fill_pool(1);
		join
		directed_checks();
		fork
			random_traffic(0, RANDOM_PER_MASTER);
			random_traffic(1, RANDOM_PER_MASTER);
		join
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
design/soc_pkg.sv
design/wb_master_port.sv
design/wb_slave_arbiter.sv
design/sram_bank_pair.sv
design/experiar_soc.sv
sim/tb_experiar_soc.sv
